/* logic/rom_loader_pkg.sv */
//////////////////////////////////////////////////////////////////////
// Shared widths, page numbers and the download address word used by
// the ROM loader. Modules take these through a wildcard import in the
// body and through scoped names in their port lists.
//////////////////////////////////////////////////////////////////////

package rom_loader_pkg;

	localparam int mem_addr_w      = 23;  // Memory word address
	localparam int dl_addr_w       = 25;  // Host download address
	localparam int page_w          = 9;   // Bit 8 marks upper-ROM region
	localparam int strobe_div      = 16;  // Clocks per reference strobe
	localparam int boot_slot_count = 8;

	localparam logic [page_w-1:0] page_mf2     = 9'h1FF;
	localparam logic [page_w-1:0] page_bad_ext = 9'h1EE; // Unused page for bad extensions

	// One download address, read two ways
	typedef union packed {
		struct packed {
			logic [10:0] slot;      // Boot image slot
			logic [13:0] offset;    // Byte within a 16 KB page
		} slot_v;
		struct packed {
			logic [2:0]  unused;
			logic [7:0]  page_ofs;  // Page count from the start page
			logic [13:0] offset;
		} page_v;
	} dl_addr_t;

	typedef logic [1:0] boot_bank_t;

endpackage

/* logic/ref_strobe_timer.sv */
//////////////////////////////////////////////////////////////////////
// Free-running divider for the memory reference strobe. The strobe
// is high for one clock per period and paces every loader write.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ref_strobe_timer #(
	parameter int period = rom_loader_pkg::strobe_div
) (
	input  logic clk_sys,
	input  logic reset,
	output logic strobe
);

	localparam int cnt_w = $clog2(period);

	logic [cnt_w-1:0] cnt;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cnt    <= '0;
			strobe <= 1'b0;
		end else begin
			strobe <= (cnt == cnt_w'(period - 1)); // Pulse on wrap
			if (cnt == cnt_w'(period - 1))
				cnt <= '0;
			else
				cnt <= cnt + 1'b1;
		end
	end

endmodule

/* logic/ext_page_decoder.sv */
//////////////////////////////////////////////////////////////////////
// Start page for an expansion ROM download, taken from the two
// extension characters when the download begins. "ZZ" loads at page
// 0 and "Z0" is a combo image that continues at the MF2 page.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ext_page_decoder (
	input  logic                              clk_sys,
	input  logic                              reset,
	input  logic                              download,
	input  logic [7:0]                        index,
	input  logic [15:0]                       file_ext,
	input  logic                              page_advance,
	output logic [rom_loader_pkg::page_w-1:0] start_page,
	output logic                              combo
);

	import rom_loader_pkg::*;

	logic              old_download;
	logic [page_w-1:0] ext_page;
	logic              ext_combo;

	// A character that is not a hex digit keeps the default nibble
	function automatic logic [3:0] hex_nibble(input logic [7:0] c, input logic [3:0] dflt);
		logic [3:0] n;
		n = dflt;
		if (c >= "0" && c <= "9")
			n = c[3:0];
		if (c >= "A" && c <= "F")
			n = c[3:0] + 4'd9;
		return n;
	endfunction

	always_comb begin
		ext_page  = {page_bad_ext[8],
		             hex_nibble(file_ext[15:8], page_bad_ext[7:4]),
		             hex_nibble(file_ext[7:0], page_bad_ext[3:0])};
		ext_combo = 1'b0;
		if (file_ext == "ZZ")
			ext_page = '0;
		if (file_ext == "Z0") begin
			ext_page  = '0;
			ext_combo = 1'b1;    // Second 16 KB goes to the MF2 page
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			old_download <= 1'b0;
			start_page   <= '0;
			combo        <= 1'b0;
		end else begin
			old_download <= download;
			if (download && !old_download && |index) begin
				start_page <= ext_page;
				combo      <= ext_combo;
			end else if (page_advance) begin
				start_page <= page_mf2;
				combo      <= 1'b0;
			end
		end
	end

endmodule

/* logic/boot_addr_mapper.sv */
//////////////////////////////////////////////////////////////////////
// Captures each accepted download byte and forms its memory address
// and bank. Boot images (index 0) go by slot number, expansion ROMs
// by start page plus page offset.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module boot_addr_mapper (
	input  logic                                  clk_sys,
	input  logic                                  reset,
	input  logic                                  wr,
	input  logic [7:0]                            index,
	input  rom_loader_pkg::dl_addr_t              addr,
	input  logic [7:0]                            data,
	input  logic [rom_loader_pkg::page_w-1:0]     start_page,
	input  logic                                  set_bank1,
	output logic [rom_loader_pkg::mem_addr_w-1:0] cur_addr,
	output rom_loader_pkg::boot_bank_t            cur_bank,
	output logic [7:0]                            cur_data,
	output logic                                  slot_valid
);

	import rom_loader_pkg::*;

	logic [page_w-1:0] slot_page;

	// Slots 0-3 and 4-7 share the same four pages
	always_comb begin
		case (addr.slot_v.slot[1:0])
			2'd0:    slot_page = 9'h000;
			2'd1:    slot_page = 9'h100;
			2'd2:    slot_page = 9'h107;
			default: slot_page = page_mf2;
		endcase
	end

	// Captured byte and its memory address
	always_ff @(posedge clk_sys) begin
		if (wr) begin
			cur_data       <= data;
			cur_addr[13:0] <= addr.slot_v.offset;
			if (|index) begin
				cur_addr[mem_addr_w-1]    <= start_page[page_w-1];
				cur_addr[mem_addr_w-2:14] <= start_page[7:0] + addr.page_v.page_ofs;
			end else begin
				cur_addr[mem_addr_w-1:14] <= slot_page;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cur_bank   <= 2'd0;
			slot_valid <= 1'b0;
		end else if (wr) begin
			if (|index) begin
				cur_bank   <= {1'b0, &index[7:6]};
				slot_valid <= 1'b1;
			end else begin
				cur_bank   <= {1'b0, addr.slot_v.slot[2]}; // Upper slots use bank 1
				slot_valid <= (addr.slot_v.slot < boot_slot_count);
			end
		end else if (set_bank1) begin
			cur_bank <= 2'd1;   // Second copy of an expansion byte
		end
	end

endmodule

/* logic/rom_write_fsm.sv */
//////////////////////////////////////////////////////////////////////
// Write sequencer. Holds the host off with wait_req, paces each
// memory write over one strobe period and repeats expansion bytes in
// bank 1. Also marks loaded upper-ROM pages and steps combo images.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module rom_write_fsm (
	input  logic                                  clk_sys,
	input  logic                                  reset,
	input  logic                                  download,
	input  logic [7:0]                            index,
	input  logic                                  wr,
	input  logic                                  strobe,
	input  logic                                  slot_valid,
	input  logic [rom_loader_pkg::mem_addr_w-1:0] cur_addr,
	input  rom_loader_pkg::boot_bank_t            cur_bank,
	input  logic                                  combo,
	output logic                                  wait_req,
	output logic                                  mem_we,
	output logic                                  set_bank1,
	output logic                                  page_advance,
	output logic                                  mark_page,
	output logic [7:0]                            mark_index
);

	import rom_loader_pkg::*;

	localparam logic [1:0] idle     = 2'd0;
	localparam logic [1:0] pending  = 2'd1;  // Byte held until the next strobe
	localparam logic [1:0] writing  = 2'd2;
	localparam logic [1:0] bank_gap = 2'd3;  // One strobe off before bank 1

	logic [1:0] state;
	logic       accept;
	logic       expansion;
	logic       double_bank;
	logic       write_end;
	logic       finish;

	assign accept      = download && wr && (index[4:0] < 5'd4); // ROM downloads only
	assign expansion   = (index[7:6] == 2'b01) || |index[5:0];
	assign double_bank = expansion && (cur_bank == 2'd0);
	assign write_end   = (state == writing) && strobe;
	assign finish      = write_end && !double_bank;

	assign set_bank1    = write_end && double_bank;
	assign mark_page    = finish && cur_addr[mem_addr_w-1];        // Upper region only
	assign mark_index   = cur_addr[mem_addr_w-2:14];
	assign page_advance = finish && combo && &cur_addr[13:0];      // Last byte of 16 KB

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state    <= idle;
			wait_req <= 1'b0;
			mem_we   <= 1'b0;
		end else begin
			case (state)
				idle: if (accept) begin
					wait_req <= 1'b1;
					state    <= pending;
				end
				pending: if (!slot_valid) begin
					wait_req <= 1'b0;   // Drop a byte from an out-of-range slot
					state    <= idle;
				end else if (strobe) begin
					mem_we <= 1'b1;
					state  <= writing;
				end
				writing: if (strobe) begin
					mem_we <= 1'b0;
					if (double_bank) begin
						state <= bank_gap;
					end else begin
						wait_req <= 1'b0;
						state    <= idle;
					end
				end
				default: if (strobe) begin
					mem_we <= 1'b1;
					state  <= writing;
				end
			endcase
		end
	end

endmodule

/* logic/rom_page_map.sv */
//////////////////////////////////////////////////////////////////////
// Loaded-page record for the upper-ROM region. Reads of a page that
// never received an image get an all-ones mask so the bus floats high.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module rom_page_map (
	input  logic                                  clk_sys,
	input  logic                                  reset,
	input  logic                                  mark_page,
	input  logic [7:0]                            mark_index,
	input  logic [rom_loader_pkg::mem_addr_w-1:0] lookup_addr,
	output logic [7:0]                            rom_mask
);

	import rom_loader_pkg::*;

	logic [255:0] loaded;     // One flag per upper page
	logic [7:0]   map_addr;
	logic         map_upper;

	always_ff @(posedge clk_sys) begin
		map_addr  <= lookup_addr[mem_addr_w-2:14];
		map_upper <= lookup_addr[mem_addr_w-1];
	end

	always_ff @(posedge clk_sys) begin
		if (reset)
			loaded <= '0;
		else if (mark_page)
			loaded[mark_index] <= 1'b1;
	end

	assign rom_mask = {8{map_upper & ~loaded[map_addr]}};

endmodule

/* logic/rom_loader.sv */
//////////////////////////////////////////////////////////////////////
// ROM loader top level. Takes ROM images from the host download port,
// writes them to memory on the reference strobe and keeps the read
// mask for unloaded upper-ROM pages.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module rom_loader #(
	parameter int strobe_period = rom_loader_pkg::strobe_div
) (
	input  logic                                  clk_sys,
	input  logic                                  reset,
	input  logic                                  download,
	input  logic [7:0]                            index,
	input  logic [15:0]                           file_ext,
	input  logic                                  wr,
	input  logic [rom_loader_pkg::dl_addr_w-1:0]  addr,
	input  logic [7:0]                            data,
	output logic                                  wait_req,
	output logic                                  mem_we,
	output logic [rom_loader_pkg::mem_addr_w-1:0] mem_addr,
	output rom_loader_pkg::boot_bank_t            mem_bank,
	output logic [7:0]                            mem_data,
	input  logic [rom_loader_pkg::mem_addr_w-1:0] lookup_addr,
	output logic [7:0]                            rom_mask
);

	import rom_loader_pkg::*;

	logic              strobe;
	logic [page_w-1:0] start_page;
	logic              combo;
	logic              page_advance;
	logic              slot_valid;
	logic              set_bank1;
	logic              mark_page;
	logic [7:0]        mark_index;
	logic              rom_wr;

	// Bytes of tape and other downloads never reach the mapper
	assign rom_wr = download && wr && (index[4:0] < 5'd4);

	ref_strobe_timer #(.period(strobe_period)) u_timer (
		.clk_sys (clk_sys),
		.reset   (reset),
		.strobe  (strobe)
	);

	ext_page_decoder u_ext_dec (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.download     (download),
		.index        (index),
		.file_ext     (file_ext),
		.page_advance (page_advance),
		.start_page   (start_page),
		.combo        (combo)
	);

	boot_addr_mapper u_mapper (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.wr         (rom_wr),
		.index      (index),
		.addr       (addr),
		.data       (data),
		.start_page (start_page),
		.set_bank1  (set_bank1),
		.cur_addr   (mem_addr),
		.cur_bank   (mem_bank),
		.cur_data   (mem_data),
		.slot_valid (slot_valid)
	);

	rom_write_fsm u_fsm (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.download     (download),
		.index        (index),
		.wr           (wr),
		.strobe       (strobe),
		.slot_valid   (slot_valid),
		.cur_addr     (mem_addr),
		.cur_bank     (mem_bank),
		.combo        (combo),
		.wait_req     (wait_req),
		.mem_we       (mem_we),
		.set_bank1    (set_bank1),
		.page_advance (page_advance),
		.mark_page    (mark_page),
		.mark_index   (mark_index)
	);

	rom_page_map u_page_map (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.mark_page   (mark_page),
		.mark_index  (mark_index),
		.lookup_addr (lookup_addr),
		.rom_mask    (rom_mask)
	);

endmodule

/* verif/rom_loader_properties.sv */
//////////////////////////////////////////////////////////////////////
// Concurrent checks bound into the write FSM of the ROM loader.
// They cover the host handshake and the pacing of memory writes.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module rom_loader_properties (
	input logic clk_sys,
	input logic reset,
	input logic wr,
	input logic strobe,
	input logic wait_req,
	input logic mem_we
);

	// Host writes only while the loader is free
	a_wr_when_free: assert property (@(posedge clk_sys) disable iff (reset) wr |-> !wait_req)
		else $error("wr arrived while wait_req was high");

	a_we_on_strobe: assert property (@(posedge clk_sys) disable iff (reset)
		$rose(mem_we) |-> $past(strobe))
		else $error("mem_we rose without a reference strobe");

	// A write always sits inside a busy period
	a_we_in_busy: assert property (@(posedge clk_sys) disable iff (reset) mem_we |-> wait_req)
		else $error("mem_we was high while wait_req was low");

endmodule

bind rom_write_fsm rom_loader_properties u_properties (
	.clk_sys  (clk_sys),
	.reset    (reset),
	.wr       (wr),
	.strobe   (strobe),
	.wait_req (wait_req),
	.mem_we   (mem_we)
);

/* verif/rom_loader_checker.sv */
//////////////////////////////////////////////////////////////////////
// Scoreboard for the ROM loader. Predicts the memory writes of each
// host byte seen on the download port, compares them in order with
// the writes the DUT makes, and predicts and checks rom_mask.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module rom_loader_checker (
	input  logic                                  clk_sys,
	input  logic                                  reset,
	input  logic                                  download,
	input  logic [7:0]                            index,
	input  logic [15:0]                           file_ext,
	input  logic                                  wr,
	input  logic [rom_loader_pkg::dl_addr_w-1:0]  addr,
	input  logic [7:0]                            data,
	input  logic                                  wait_req,
	input  logic                                  mem_we,
	input  logic [rom_loader_pkg::mem_addr_w-1:0] mem_addr,
	input  logic [1:0]                            mem_bank,
	input  logic [7:0]                            mem_data,
	input  logic [rom_loader_pkg::mem_addr_w-1:0] lookup_addr,
	input  logic [7:0]                            rom_mask,
	output int                                    error_count,
	output int                                    write_count,
	output int                                    pending
);

	logic [33:0]  exp_q[$];     // last, bank, page, offset, data
	logic [255:0] ref_loaded;
	logic [8:0]   ref_start;
	logic         ref_combo;
	logic         old_download;
	logic         old_mem_we;
	logic [22:0]  old_lookup;

	function automatic logic [3:0] char_value(input logic [7:0] c, input logic [3:0] fallback);
		if (c inside {["0":"9"]})
			return 4'(c - "0");
		if (c inside {["A":"F"]})
			return 4'(c - "A" + 8'd10);
		return fallback;
	endfunction

	// Expected memory page of one byte. Bit 9 flags a dropped byte
	function automatic logic [9:0] expected_page(input logic [7:0] idx, input logic [24:0] a,
	                                             input logic [8:0] start);
		if (idx != 8'd0)
			return {1'b0, start[8], 8'(start[7:0] + a[21:14])};
		if (a[24:14] >= 11'd8)
			return 10'h200;
		case (a[15:14])
			2'd0:    return 10'h000;
			2'd1:    return 10'h100;
			2'd2:    return 10'h107;
			default: return 10'h1FF;
		endcase
	endfunction

	always @(posedge clk_sys) begin
		logic [9:0]  page;
		logic [1:0]  bank;
		logic        twice;
		logic [33:0] e;
		logic [7:0]  want;
		if (reset) begin
			exp_q.delete();
			ref_loaded  = '0;
			ref_start   = '0;
			ref_combo   = 1'b0;
			error_count = 0;
			write_count = 0;
		end else begin
			if (download && !old_download && index != 8'd0) begin
				ref_start = {1'b1, char_value(file_ext[15:8], 4'hE),
				             char_value(file_ext[7:0], 4'hE)};
				if (file_ext == "ZZ" || file_ext == "Z0")
					ref_start = 9'h000;
				ref_combo = (file_ext == "Z0");
			end
			if (download && wr && index[4:0] < 5'd4) begin
				page  = expected_page(index, addr, ref_start);
				bank  = (index == 8'd0) ? {1'b0, addr[16]} : {1'b0, &index[7:6]};
				twice = (index[7:6] == 2'b01 || index[5:0] != 6'd0) && bank == 2'd0;
				if (!page[9]) begin
					exp_q.push_back({!twice, bank, page[8:0], addr[13:0], data});
					if (twice)
						exp_q.push_back({1'b1, 2'd1, page[8:0], addr[13:0], data});
					if (ref_combo && &addr[13:0]) begin
						ref_start = 9'h1FF;   // Rest of a combo image
						ref_combo = 1'b0;
					end
				end
			end
			if (mem_we && !old_mem_we) begin
				if (exp_q.size() == 0) begin
					error_count++;
					$display("** Error at %0t: write to %h with no byte pending", $time, mem_addr);
				end else begin
					e = exp_q.pop_front();
					write_count++;
					if ({mem_bank, mem_addr, mem_data} != e[32:0]) begin
						error_count++;
						$display("** Error at %0t: write bank %0d addr %h data %h, expected %0d %h %h",
						         $time, mem_bank, mem_addr, mem_data, e[32:31], e[30:8], e[7:0]);
					end
					if (e[33] && e[30])
						ref_loaded[e[29:22]] = 1'b1;   // Upper page now holds an image
				end
			end
			// Mask follows the lookup of the previous clock
			if (!wait_req) begin
				want = {8{old_lookup[22] & ~ref_loaded[old_lookup[21:14]]}};
				if (rom_mask !== want) begin
					error_count++;
					$display("** Error at %0t: rom_mask %h for lookup %h, expected %h",
					         $time, rom_mask, old_lookup, want);
				end
			end
		end
		old_download = download;
		old_mem_we   = mem_we;
		old_lookup   = lookup_addr;
		pending      = exp_q.size();
	end

endmodule

/* verif/tb_rom_loader.sv */
//////////////////////////////////////////////////////////////////////
// Top testbench for the ROM loader. Streams boot and expansion images
// through the download port with the wait handshake, probes the read
// mask before and after, and prints the closing report.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_rom_loader;

	import rom_loader_pkg::*;

	localparam int wait_limit = 400;   // Clocks allowed per byte

	logic                  clk_sys;
	logic                  reset;
	logic                  download;
	logic [7:0]            index;
	logic [15:0]           file_ext;
	logic                  wr;
	logic [dl_addr_w-1:0]  addr;
	logic [7:0]            data;
	logic [mem_addr_w-1:0] lookup_addr;
	logic                  wait_req;
	logic                  mem_we;
	logic [mem_addr_w-1:0] mem_addr;
	boot_bank_t            mem_bank;
	logic [7:0]            mem_data;
	logic [7:0]            rom_mask;
	int                    error_count;
	int                    write_count;
	int                    pending;
	int                    handshake_errors;
	int                    timeout_count;
	logic [31:0]           rng;
	logic [8:0]            probe_list [6];

	rom_loader #(.strobe_period(strobe_div)) DUT (.*);

	rom_loader_checker u_checker (.*);

	initial begin
		clk_sys = 1'b0;
		forever #50 clk_sys = ~clk_sys;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		return x ^ (x << 5);
	endfunction

	task automatic open_download(input logic [7:0] idx, input logic [15:0] ext);
		@(posedge clk_sys);
		download <= 1'b1;
		index    <= idx;
		file_ext <= ext;
		repeat (2) @(posedge clk_sys);   // Start page latches one clock in
	endtask

	task automatic close_download();
		@(posedge clk_sys);
		download <= 1'b0;
		@(posedge clk_sys);
	endtask

	// Sends one byte with random data and holds until the loader is free
	task automatic send_byte(input logic [24:0] a);
		int cycles;
		if (timeout_count == 0) begin
			rng = xorshift(rng);
			@(posedge clk_sys);
			addr <= a;
			data <= rng[7:0];
			wr   <= 1'b1;
			@(posedge clk_sys);
			wr <= 1'b0;
			@(posedge clk_sys);
			if (!wait_req) begin
				handshake_errors++;
				$display("Handshake problem at %0t: wait_req did not rise after a byte", $time);
			end
			cycles = 0;
			while (wait_req && cycles < wait_limit) begin
				@(posedge clk_sys);
				cycles++;
			end
			if (wait_req) begin
				timeout_count++;
				$display("Timeout at %0t: wait_req stayed high after byte at %h", $time, a);
			end
		end
	endtask

	task automatic probe_pages();
		for (int i = 0; i < 6; i++) begin
			rng = xorshift(rng);
			@(posedge clk_sys);
			lookup_addr <= {probe_list[i], rng[13:0]};
			repeat (3) @(posedge clk_sys);
		end
	endtask

	initial begin
		rng              = 32'h7646_207d;
		reset            = 1'b1;
		download         = 1'b0;
		index            = 8'h00;
		file_ext         = 16'h0000;
		wr               = 1'b0;
		addr             = '0;
		data             = 8'h00;
		lookup_addr      = '0;
		handshake_errors = 0;
		timeout_count    = 0;
		probe_list       = '{9'h1EE, 9'h1FF, 9'h100, 9'h107, 9'h0A3, 9'h000};
		repeat (3) @(posedge clk_sys);
		reset <= 1'b0;
		probe_pages();

		// Boot slots 0-7 and two slots past the end
		open_download(8'h00, "  ");
		for (int slot = 0; slot < 10; slot++) begin
			rng = xorshift(rng);
			send_byte({11'(slot), rng[13:0]});
		end
		close_download();

		open_download(8'h01, "A3");
		repeat (4) begin
			rng = xorshift(rng);
			send_byte({9'd0, rng[15:0]});   // Page offset 0-3
		end
		close_download();

		open_download(8'hC0, "Q!");
		repeat (4) begin
			rng = xorshift(rng);
			send_byte({9'd0, rng[15:0]});
		end
		close_download();

		// Sparse bytes of a combo image around the end of the first 16 KB
		open_download(8'h01, "Z0");
		rng = xorshift(rng);
		send_byte({11'd0, rng[13:0]});
		send_byte({11'd0, 14'h3FFF});
		repeat (2) begin
			rng = xorshift(rng);
			send_byte({11'd0, rng[13:0]});
		end
		close_download();
		probe_pages();

		repeat (4) @(posedge clk_sys);
		$display("Done: %0d writes, %0d errors, %0d handshake errors, %0d timeouts, %0d missing",
		         write_count, error_count, handshake_errors, timeout_count, pending);
		if (error_count == 0 && handshake_errors == 0 && timeout_count == 0 && pending == 0
		    && write_count > 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

/* sim.f */
logic/rom_loader_pkg.sv
logic/ref_strobe_timer.sv
logic/ext_page_decoder.sv
logic/boot_addr_mapper.sv
logic/rom_write_fsm.sv
logic/rom_page_map.sv
logic/rom_loader.sv
verif/rom_loader_properties.sv
verif/rom_loader_checker.sv
verif/tb_rom_loader.sv

/* run_sim.sh */
#!/bin/sh
# Compile the ROM loader testbench with Verilator, run it and check the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_rom_loader -f sim.f -o tb_rom_loader

status=0
./obj_dir/tb_rom_loader > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "SIMULATION FAILED" sim.log; then
	exit 1
fi
if [ "$status" -ne 0 ] || ! grep -q "SIMULATION PASSED" sim.log; then
	echo "Simulation ended without a pass report"
	exit 1
fi
exit 0
